// File: common/emesh_pkg.sv
`include "ep_defines.svh"

package emesh_pkg;

   //########################################################################
   // Transfer size
   //########################################################################
   typedef enum logic [1:0] {
      dm_byte  = 2'b00,   // 8 bit
      dm_half  = 2'b01,   // 16 bit
      dm_word  = 2'b10,   // 32 bit
      dm_dword = 2'b11    // 64 bit, served as a word here
   } datamode_e;

   //########################################################################
   // 104-bit mesh packet
   //########################################################################
   // Field order is MSB first
   typedef struct packed {
      logic [`EP_AW-1:0] srcaddr;    // Return address of a read
      logic [31:0]       data;       // Write data or read result
      logic [`EP_AW-1:0] dstaddr;    // Target address
      logic [4:0]        ctrlmode;   // Carried through untouched
      datamode_e         datamode;
      logic              write;      // Write request or read response
   } emesh_packet_t;

   // Low bits kept for a given size
   function automatic logic [31:0] dm_mask(datamode_e dm);
      case (dm)
         dm_byte: return 32'h0000_00ff;
         dm_half: return 32'h0000_ffff;
         default: return 32'hffff_ffff;   // Word and dword
      endcase
   endfunction

endpackage

// File: common/ep_defines.svh
`ifndef EP_DEFINES_SVH
`define EP_DEFINES_SVH

// Mesh address width
`define EP_AW 32

// Local memory in 32-bit words
`define EP_MEM_WORDS 256
`define EP_MEM_AW 8

// Base of the 1 KB endpoint window
`define EP_BASE_ADDR 32'h8080_0000

`endif

// File: common/ep_pipe_pkg.sv
`include "ep_defines.svh"

package ep_pipe_pkg;

   // Decoded operation
   typedef enum logic [1:0] {
      op_none  = 2'd0,   // Idle or outside the window
      op_write = 2'd1,
      op_read  = 2'd2
   } ep_op_e;

   // Decode to memory stage
   typedef struct packed {
      logic                  valid;
      ep_op_e                op;
      logic [`EP_MEM_AW-1:0] word_idx;   // Word within the window
      logic [1:0]            byte_off;   // Byte lane of the address
      emesh_pkg::datamode_e  datamode;
      logic [31:0]           wdata;
      logic [`EP_AW-1:0]     srcaddr;
      logic [`EP_AW-1:0]     dstaddr;
      logic [4:0]            ctrlmode;
   } dec_stage_t;

   // Memory to transmit stage
   typedef struct packed {
      logic                 valid;      // Read response pending
      logic [31:0]          rdata;      // Shifted to bit 0 and masked
      logic [`EP_AW-1:0]    srcaddr;
      logic [`EP_AW-1:0]    dstaddr;
      emesh_pkg::datamode_e datamode;
      logic [4:0]           ctrlmode;
   } rsp_stage_t;

endpackage

// File: emesh_endpoint.f
+incdir+common
common/emesh_pkg.sv
common/ep_pipe_pkg.sv
hw/emesh_rx_decode.sv
hw/ep_mem/ep_mem_stage.sv
hw/emesh_tx_format.sv
hw/emesh_endpoint.sv
verification/dv_top.sv

// File: hw/emesh_endpoint.sv
`timescale 1ns/1ps

module emesh_endpoint
   import emesh_pkg::*;
   import ep_pipe_pkg::*;
(
   input  logic          clk1,
   input  logic          rst_n,
   input  logic          access_in,
   input  emesh_packet_t packet_in,
   output logic          wait_out,
   output logic          access_out,
   output emesh_packet_t packet_out,
   input  logic          wait_in
);

   logic       stall;     // Freezes all three stages
   logic       pending;   // Response waiting at the output
   dec_stage_t dec;
   rsp_stage_t rsp;

   //########################################################################
   // Global stall
   //########################################################################
   assign stall    = pending & wait_in;
   assign wait_out = stall;   // Requester holds its packet

   // Stage 1
   emesh_rx_decode u_rx_decode (
      .clk1      (clk1),
      .rst_n     (rst_n),
      .stall     (stall),
      .access_in (access_in),
      .packet_in (packet_in),
      .dec       (dec)
   );

   // Stage 2
   ep_mem_stage u_mem_stage (
      .clk1  (clk1),
      .rst_n (rst_n),
      .stall (stall),
      .dec   (dec),
      .rsp   (rsp)
   );

   // Stage 3
   emesh_tx_format u_tx_format (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .stall      (stall),
      .rsp        (rsp),
      .pending    (pending),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: hw/emesh_rx_decode.sv
`timescale 1ns/1ps
`include "ep_defines.svh"

module emesh_rx_decode
   import emesh_pkg::*;
   import ep_pipe_pkg::*;
(
   input  logic          clk1,
   input  logic          rst_n,
   input  logic          stall,
   input  logic          access_in,
   input  emesh_packet_t packet_in,
   output dec_stage_t    dec
);

   localparam logic [`EP_AW-1:0] BASE = `EP_BASE_ADDR;
   localparam int WIN_LSB = `EP_MEM_AW + 2;   // 1 KB window

   logic          acc_q;       // Input access flag
   emesh_packet_t pkt_q;       // Input packet
   logic          in_window;
   dec_stage_t    dec_nxt;

   //########################################################################
   // Input register
   //########################################################################
   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         acc_q <= 1'b0;
      end else if (!stall) begin
         acc_q <= access_in;   // Requester holds while wait_out is high
      end
   end

   always_ff @(posedge clk1) begin
      if (!stall) begin
         pkt_q <= packet_in;
      end
   end

   // Upper address bits must hit the base
   assign in_window = (pkt_q.dstaddr[`EP_AW-1:WIN_LSB] == BASE[`EP_AW-1:WIN_LSB]);

   //########################################################################
   // Classify
   //########################################################################
   always_comb begin
      dec_nxt          = '0;
      dec_nxt.valid    = acc_q;
      if (!acc_q || !in_window) dec_nxt.op = op_none;   // Dropped silently
      else if (pkt_q.write)     dec_nxt.op = op_write;
      else                      dec_nxt.op = op_read;
      dec_nxt.word_idx = pkt_q.dstaddr[WIN_LSB-1:2];
      dec_nxt.byte_off = pkt_q.dstaddr[1:0];
      dec_nxt.datamode = pkt_q.datamode;
      dec_nxt.wdata    = pkt_q.data;
      dec_nxt.srcaddr  = pkt_q.srcaddr;
      dec_nxt.dstaddr  = pkt_q.dstaddr;
      dec_nxt.ctrlmode = pkt_q.ctrlmode;
   end

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         dec <= '0;
      end else if (!stall) begin
         dec <= dec_nxt;
      end
   end

   // Both registers frozen through a stall
   a_hold_on_stall: assert property (@(posedge clk1) disable iff (!rst_n)
      stall |=> $stable(acc_q) && $stable(dec));

endmodule

// File: hw/emesh_tx_format.sv
`timescale 1ns/1ps

module emesh_tx_format
   import emesh_pkg::*;
   import ep_pipe_pkg::*;
(
   input  logic          clk1,
   input  logic          rst_n,
   input  logic          stall,
   input  rsp_stage_t    rsp,
   output logic          pending,
   output logic          access_out,
   output emesh_packet_t packet_out
);

   emesh_packet_t pkt_nxt;

   //########################################################################
   // Response packet
   //########################################################################
   always_comb begin
      pkt_nxt.write    = 1'b1;            // Responses travel as writes
      pkt_nxt.dstaddr  = rsp.srcaddr;     // Back to the requester
      pkt_nxt.srcaddr  = rsp.dstaddr;
      pkt_nxt.data     = rsp.rdata;
      pkt_nxt.datamode = rsp.datamode;
      pkt_nxt.ctrlmode = rsp.ctrlmode;
   end

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         access_out <= 1'b0;
      end else if (!stall) begin
         access_out <= rsp.valid;
      end
   end

   // Held as is while the receiver waits
   always_ff @(posedge clk1) begin
      if (!stall) begin
         packet_out <= pkt_nxt;
      end
   end

   assign pending = access_out;

   // Output frozen under wait_in
   a_out_stable: assert property (@(posedge clk1) disable iff (!rst_n)
      stall |=> access_out && $stable(packet_out));

endmodule

// File: hw/ep_mem/ep_mem_stage.sv
`timescale 1ns/1ps
`include "ep_defines.svh"

module ep_mem_stage
   import ep_pipe_pkg::*;
   import emesh_pkg::*;
(
   input  logic       clk1,
   input  logic       rst_n,
   input  logic       stall,
   input  dec_stage_t dec,
   output rsp_stage_t rsp
);

   logic [31:0] mem [`EP_MEM_WORDS];   // Local store

   logic [1:0]  lane_off;        // Offset aligned down to the size
   logic [3:0]  byte_en;
   logic [31:0] wdata_rep;       // Write data copied onto all lanes
   logic [31:0] rd_word;
   logic [31:0] rd_shift;
   logic        misaligned;
   logic        misalign_seen;   // Sticky flag
   rsp_stage_t  rsp_nxt;

   //########################################################################
   // Lane selection
   //########################################################################
   always_comb begin
      case (dec.datamode)
         dm_byte: begin
            lane_off  = dec.byte_off;
            byte_en   = 4'b0001 << dec.byte_off;
            wdata_rep = {4{dec.wdata[7:0]}};
         end
         dm_half: begin
            lane_off  = {dec.byte_off[1], 1'b0};   // Odd offset rounds down
            byte_en   = 4'b0011 << {dec.byte_off[1], 1'b0};
            wdata_rep = {2{dec.wdata[15:0]}};
         end
         default: begin                            // Word and dword
            lane_off  = 2'b00;
            byte_en   = 4'b1111;
            wdata_rep = dec.wdata;
         end
      endcase
   end

   assign misaligned = dec.valid && (dec.op != op_none) && (dec.byte_off != lane_off);

   //########################################################################
   // Memory array
   //########################################################################
   always_ff @(posedge clk1) begin
      if (!stall && dec.valid && (dec.op == op_write)) begin
         for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) mem[dec.word_idx][8*i +: 8] <= wdata_rep[8*i +: 8];
         end
      end
   end

   // Read sees any write retired on an earlier edge
   assign rd_word  = mem[dec.word_idx];
   assign rd_shift = rd_word >> {lane_off, 3'b000};

   always_comb begin
      rsp_nxt          = '0;
      rsp_nxt.valid    = dec.valid && (dec.op == op_read);   // Only reads respond
      rsp_nxt.rdata    = rd_shift & dm_mask(dec.datamode);
      rsp_nxt.srcaddr  = dec.srcaddr;
      rsp_nxt.dstaddr  = dec.dstaddr;
      rsp_nxt.datamode = dec.datamode;
      rsp_nxt.ctrlmode = dec.ctrlmode;
   end

   always_ff @(posedge clk1 or negedge rst_n) begin
      if (!rst_n) begin
         rsp           <= '0;
         misalign_seen <= 1'b0;
      end else if (!stall) begin
         rsp <= rsp_nxt;
         if (misaligned) misalign_seen <= 1'b1;
      end
   end

   // Odd halfword access must leave the misalign flag set
   a_half_align: assert property (@(posedge clk1) disable iff (!rst_n)
      (!stall && dec.valid && (dec.op != op_none) && (dec.datamode == dm_half)
       && dec.byte_off[0]) |=> misalign_seen);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module dv_top -f emesh_endpoint.f -Mdir obj_dir -o dv_top; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/dv_top)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test OK" <<< "$sim_out"; then
   exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: verification/dv_top.sv
`timescale 1ns/1ps

module dv_top
   import emesh_pkg::*;
();

   localparam int    CLK_PERIOD   = 100;   // ns
   localparam int    RESET_CYCLES = 16;
   localparam int    MAX_LINES    = 64;
   localparam int    DRAIN_CYCLES = 8;     // Quiet tail that catches stray responses
   localparam string STIM_FILE    = "verification/emesh_stim.txt";

   logic          clk1 = 1'b0;
   logic          rst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   // Stimulus table, one entry per data line
   emesh_packet_t   req_tab  [MAX_LINES];
   logic [8*16-1:0] name_tab [MAX_LINES];
   logic            has_rsp  [MAX_LINES];   // Dash in the file clears it
   logic [31:0]     exp_tab  [MAX_LINES];
   int              n_lines     = 0;
   logic            stim_loaded = 1'b0;

   // Responses still owed, oldest first
   emesh_packet_t   exp_q[$];
   logic [8*16-1:0] exp_name_q[$];

   int            value_errs   = 0;
   int            other_errs   = 0;
   int            timeout_errs = 0;
   logic [31:0]   lfsr_state   = 32'h3ed9fec1;
   logic          hold_active  = 1'b0;   // Output stalled last cycle
   emesh_packet_t held_pkt;

   emesh_endpoint u_emesh_endpoint (
      .clk1       (clk1),
      .rst_n      (rst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #(CLK_PERIOD / 2) clk1 = ~clk1;

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   //########################################################################
   // Stimulus file
   //########################################################################
   task automatic load_stim();
      int               fd;
      int               cnt;
      logic [8*128-1:0] line;
      logic [8*16-1:0]  nm;
      logic [8*16-1:0]  exp_txt;
      logic [31:0]      wr;
      logic [31:0]      dm;
      logic [31:0]      dst;
      logic [31:0]      dat;
      logic [31:0]      src;
      logic [31:0]      val;
      fd = $fopen(STIM_FILE, "r");
      assert (fd != 0) else begin
         $display("Error: cannot open stimulus file %0s", STIM_FILE);
         other_errs++;
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = '0;
            cnt  = $fgets(line, fd);
            cnt  = $sscanf(line, "%s %h %h %h %h %h %s", nm, wr, dm, dst, dat, src, exp_txt);
            if (cnt == 7 && n_lines < MAX_LINES) begin   // Comments fall short
               req_tab[n_lines]          = '0;
               req_tab[n_lines].write    = wr[0];
               req_tab[n_lines].datamode = datamode_e'(dm[1:0]);
               req_tab[n_lines].dstaddr  = dst;
               req_tab[n_lines].data     = dat;
               req_tab[n_lines].srcaddr  = src;
               req_tab[n_lines].ctrlmode = 5'(n_lines);   // Line index as a tag
               name_tab[n_lines]         = nm;
               has_rsp[n_lines]          = (exp_txt != {120'd0, "-"});
               val                       = '0;
               if (has_rsp[n_lines]) cnt = $sscanf(exp_txt, "%h", val);
               exp_tab[n_lines]          = val;
               n_lines++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Response is a write back to the requester
   task automatic expect_response(input int idx);
      emesh_packet_t want;
      want          = '0;
      want.write    = 1'b1;
      want.dstaddr  = req_tab[idx].srcaddr;   // Swapped addresses
      want.srcaddr  = req_tab[idx].dstaddr;
      want.data     = exp_tab[idx];
      want.datamode = req_tab[idx].datamode;
      want.ctrlmode = req_tab[idx].ctrlmode;
      exp_q.push_back(want);
      exp_name_q.push_back(name_tab[idx]);
   endtask

   //########################################################################
   // Checking
   //########################################################################
   task automatic check_field(input logic [8*16-1:0] name, input string field,
                              input logic [31:0] want, input logic [31:0] act);
      assert (act === want) else begin
         $display("Fail %0s %0s: expected %h, actual %h", name, field, want, act);
         value_errs++;
      end
   endtask

   task automatic check_response();
      emesh_packet_t   want;
      logic [8*16-1:0] name;
      assert (exp_q.size() > 0) else begin
         $display("Error: response to %h arrived with no read outstanding",
                  packet_out.dstaddr);
         other_errs++;
      end
      if (exp_q.size() > 0) begin
         want = exp_q.pop_front();
         name = exp_name_q.pop_front();
         check_field(name, "data", want.data, packet_out.data);
         check_field(name, "dstaddr", want.dstaddr, packet_out.dstaddr);
         check_field(name, "srcaddr", want.srcaddr, packet_out.srcaddr);
         check_field(name, "write", 32'(want.write), 32'(packet_out.write));
         check_field(name, "datamode", 32'(want.datamode), 32'(packet_out.datamode));
         check_field(name, "ctrlmode", 32'(want.ctrlmode), 32'(packet_out.ctrlmode));
      end
   endtask

   task automatic sample_outputs();
      if (hold_active) begin   // Stalled on the last edge
         assert (access_out && (packet_out === held_pkt)) else begin
            $display("Error: response changed while wait_in was high");
            other_errs++;
         end
      end
      hold_active = access_out && wait_in;
      held_pkt    = packet_out;
      if (access_out && !wait_in) check_response();   // Taken on next edge
   endtask

   task automatic report_and_finish();
      $display("Errors: %0d mismatch, %0d other, %0d timeout",
               value_errs, other_errs, timeout_errs);
      if (value_errs + other_errs + timeout_errs == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   endtask

   //########################################################################
   // Requester and receiver
   //########################################################################
   initial begin : stimulus
      int   idx;
      int   drain;
      logic req_taken;
      logic b0;
      logic b1;
      rst_n     = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      idx       = 0;
      drain     = 0;
      load_stim();
      stim_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk1);
      @(negedge clk1);
      rst_n = 1'b1;
      while (drain < DRAIN_CYCLES) begin
         @(negedge clk1);
         if (idx < n_lines) begin   // Same request again until taken
            access_in = 1'b1;
            packet_in = req_tab[idx];
         end else begin
            access_in = 1'b0;
            packet_in = '0;
         end
         lfsr_state = lfsr_next(lfsr_state);
         b0         = lfsr_state[0];
         lfsr_state = lfsr_next(lfsr_state);
         b1         = lfsr_state[0];
         wait_in    = b0 & b1;   // High about a quarter of the time
         // Handshakes settled well ahead of the rising edge
         #(CLK_PERIOD / 4);
         req_taken = access_in && !wait_out;
         if (req_taken) begin
            if (has_rsp[idx]) expect_response(idx);
            idx++;
         end
         sample_outputs();
         if (idx >= n_lines && exp_q.size() == 0) drain++;
      end
      report_and_finish();
   end

   initial begin : watchdog
      wait (stim_loaded);
      #((RESET_CYCLES + n_lines * 40) * CLK_PERIOD);
      $display("Error: watchdog expired before all responses arrived");
      timeout_errs++;
      report_and_finish();
   end

endmodule

// File: verification/emesh_stim.txt
# name          wr dm dstaddr  data     srcaddr  expected read data
# wr 1 write 0 read, dm 0 byte 1 half 2 word 3 dword, dash marks no response
wr_word0        1 2 80800000 deadbeef 00000000 -
rd_word0        0 2 80800000 00000000 81000000 deadbeef
wr_word1        1 2 80800004 12345678 00000000 -
wr_byte5        1 0 80800005 000000aa 00000000 -
wr_half6        1 1 80800006 0000cdef 00000000 -
rd_merged1      0 2 80800004 00000000 81000004 cdefaa78
rd_byte4        0 0 80800004 00000000 81000008 00000078
rd_byte5        0 0 80800005 00000000 8100000c 000000aa
rd_byte7        0 0 80800007 00000000 81000010 000000cd
rd_half4        0 1 80800004 00000000 81000014 0000aa78
rd_half6        0 1 80800006 00000000 81000018 0000cdef
drop_rd_hi      0 2 80800400 00000000 8100001c -
drop_rd_far     0 2 90000000 00000000 81000020 -
rd_after_drop   0 2 80800000 00000000 81000024 deadbeef
drop_wr         1 2 80800404 11111111 00000000 -
rd_no_alias     0 2 80800004 00000000 81000028 cdefaa78
raw_wr_word     1 2 808003fc a5a55a5a 00000000 -
raw_rd_word     0 2 808003fc 00000000 8100002c a5a55a5a
raw_wr_byte     1 0 808003fd 000000c3 00000000 -
raw_rd_merged   0 2 808003fc 00000000 81000030 a5a5c35a
wr_word40       1 2 80800100 00000000 00000000 -
raw_wr_half     1 1 80800102 0000beef 00000000 -
raw_rd_half     0 1 80800102 00000000 81000034 0000beef
rd_word40       0 2 80800100 00000000 81000038 beef0000
wr_dword2       1 3 80800008 76543210 00000000 -
rd_dword2       0 3 80800008 00000000 8100003c 76543210
rd_byte9        0 0 80800009 00000000 81000040 00000032
rd_burst_a      0 2 808003fc 00000000 81000044 a5a5c35a
rd_burst_b      0 1 80800006 00000000 81000048 0000cdef
rd_burst_c      0 0 80800102 00000000 8100004c 000000ef
